//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= files.f
TOP       ?= issue_tb
LINT_TOP  ?= issue_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST PASS" $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) --lint-only hw/issue_pkg.sv hw/inst_fifo.sv hw/inst_decode.sv \
		hw/issue_ctrl.sv hw/pipe_tracker.sv hw/issue_top.sv --top-module $(LINT_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
    parameter real PERIOD_NS    = 8.0,
    parameter int  RESET_CYCLES = 10
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;  // release away from the sampling edge
    end

endmodule

//--- bench/issue_tb.sv
`timescale 1ns/1ps

module issue_tb;
    import issue_pkg::*;

    localparam int          MAX_CASES    = 8;
    localparam int          MAX_LEN      = 6;
    localparam int          CASE_TIMEOUT = 50;
    localparam int          FILL_COUNT   = 14;
    localparam int unsigned SEED         = 32'h832ea556;
    localparam funct_t      FN_ADD       = 6'h20;

    logic   clk;
    logic   arst_n;
    logic   push;
    instr_t push_instr;
    logic   fifo_full;
    issue_t master_out;
    issue_t slave_out;
    logic   slave_in_delayslot;

    string  case_name  [MAX_CASES];
    int     case_len   [MAX_CASES];
    instr_t case_instr [MAX_CASES][MAX_LEN];
    int     ev_cnt     [MAX_CASES];
    int     ev_m       [MAX_CASES][MAX_LEN];  // index into case_instr
    int     ev_s       [MAX_CASES][MAX_LEN];  // -1 when master issues alone
    logic   ev_ds      [MAX_CASES][MAX_LEN];
    int     n_cases;
    int     mismatches;
    int     failures;
    int unsigned seed_val;

    clk_gen #(.PERIOD_NS(8.0), .RESET_CYCLES(10)) u_clk (.clk(clk), .arst_n(arst_n));

    issue_top UUT (
        .clk                (clk),
        .arst_n             (arst_n),
        .push               (push),
        .push_instr         (push_instr),
        .fifo_full          (fifo_full),
        .master_out         (master_out),
        .slave_out          (slave_out),
        .slave_in_delayslot (slave_in_delayslot)
    );

    function automatic instr_t enc_i(opcode_t op, reg_addr_t rs, reg_addr_t rt,
                                     logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic instr_t enc_r(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd, funct_t fn);
        return {OP_R_TYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic instr_t enc_j(opcode_t op, logic [25:0] target);
        return {op, target};
    endfunction

    function automatic issue_t slot(logic valid, instr_t instr);
        issue_t s;
        s.valid = valid;
        s.instr = instr;
        return s;
    endfunction

    task automatic new_case(input string name);
        case_name[n_cases] = name;
        case_len[n_cases]  = 0;
        ev_cnt[n_cases]    = 0;
        n_cases++;
    endtask

    task automatic add_instr(input instr_t instr);
        int c;
        c = n_cases - 1;
        case_instr[c][case_len[c]] = instr;
        case_len[c]++;
    endtask

    task automatic add_event(input int m, input int s, input logic ds);
        int c;
        c = n_cases - 1;
        ev_m[c][ev_cnt[c]]  = m;
        ev_s[c][ev_cnt[c]]  = s;
        ev_ds[c][ev_cnt[c]] = ds;
        ev_cnt[c]++;
    endtask

    task automatic check_issue(input string name, input issue_t exp, input issue_t act);
        if (act.valid !== exp.valid || (exp.valid && act.instr !== exp.instr)) begin
            $display("Mismatch %s: expected valid=%0b instr=%08h, actual valid=%0b instr=%08h",
                     name, exp.valid, exp.instr, act.valid, act.instr);
            mismatches++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Mismatch %s: expected %0b, actual %0b", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic build_table();
        reg_addr_t a;
        reg_addr_t b;
        reg_addr_t c;
        reg_addr_t d;
        new_case("indep_alu");
        add_instr(enc_i(OP_ADDI, 2, 1, 16'd5));
        add_instr(enc_i(OP_ADDI, 4, 3, 16'd7));
        add_instr(enc_i(OP_ORI, 6, 5, 16'h00ff));
        add_instr(enc_r(8, 9, 7, FN_ADD));
        add_instr(enc_i(OP_ADDI, 11, 10, 16'd1));
        add_event(0, 1, 1'b0);
        add_event(2, 3, 1'b0);
        add_event(4, -1, 1'b0);  // last one has no partner
        new_case("raw_rs");
        add_instr(enc_i(OP_ADDI, 2, 1, 16'd1));
        add_instr(enc_i(OP_ADDI, 1, 3, 16'd2));
        add_instr(enc_i(OP_ADDI, 6, 5, 16'd3));
        add_instr(enc_i(OP_ADDI, 8, 7, 16'd4));
        add_event(0, -1, 1'b0);
        add_event(1, 2, 1'b0);
        add_event(3, -1, 1'b0);
        new_case("raw_rt_and_r0");
        add_instr(enc_i(OP_ORI, 0, 4, 16'd3));
        add_instr(enc_r(6, 4, 5, FN_ADD));
        add_instr(enc_i(OP_ADDI, 8, 7, 16'd1));
        add_instr(enc_r(9, 10, 0, FN_ADD));  // writes r0
        add_instr(enc_i(OP_ADDI, 0, 11, 16'd2));
        add_event(0, -1, 1'b0);
        add_event(1, 2, 1'b0);
        add_event(3, 4, 1'b0);
        new_case("load_hilo_cop0");
        add_instr(enc_i(OP_ADDI, 2, 1, 16'd1));
        add_instr(enc_i(OP_LW, 4, 3, 16'd0));
        add_instr(enc_i(OP_ADDI, 6, 5, 16'd1));
        add_instr(enc_r(7, 8, 0, FN_MULT));
        add_instr(enc_i(OP_COP0, 0, 0, 16'd0));
        add_instr(enc_i(OP_ADDI, 10, 9, 16'd1));
        for (int i = 0; i < 6; i++) begin
            add_event(i, -1, 1'b0);
        end
        new_case("store_branch");
        add_instr(enc_i(OP_ADDI, 2, 1, 16'd1));
        add_instr(enc_i(OP_SW, 4, 3, 16'd0));
        add_instr(enc_i(OP_ADDI, 6, 5, 16'd1));
        add_instr(enc_i(OP_BEQ, 7, 8, 16'd4));
        add_instr(enc_i(OP_ADDI, 10, 9, 16'd1));
        add_event(0, -1, 1'b0);
        add_event(1, -1, 1'b0);
        add_event(2, -1, 1'b0);
        add_event(3, 4, 1'b1);
        new_case("delay_slot");
        add_instr(enc_i(OP_BNE, 1, 2, 16'd4));
        add_instr(enc_i(OP_ADDI, 4, 3, 16'd1));
        add_instr(enc_j(OP_JAL, 26'h40));
        add_instr(enc_i(OP_ADDI, 31, 5, 16'd1));  // reads the link register
        add_instr(enc_i(OP_ADDI, 7, 6, 16'd1));
        add_event(0, 1, 1'b1);
        add_event(2, -1, 1'b0);
        add_event(3, 4, 1'b0);
        new_case("load_use");
        add_instr(enc_i(OP_LW, 2, 1, 16'd8));
        add_instr(enc_i(OP_ADDI, 1, 3, 16'd1));
        add_instr(enc_i(OP_ADDI, 5, 4, 16'd1));
        add_instr(enc_i(OP_ADDI, 7, 6, 16'd1));
        add_event(0, -1, 1'b0);
        add_event(1, 2, 1'b0);
        add_event(3, -1, 1'b0);
        // random registers, pairing follows the rs dependence rule
        a = reg_addr_t'($urandom);
        b = reg_addr_t'($urandom);
        c = reg_addr_t'($urandom);
        d = reg_addr_t'($urandom);
        new_case("indep_rand");
        add_instr(enc_i(OP_ADDI, b, a, 16'd9));
        add_instr(enc_i(OP_ADDI, d, c, 16'd3));
        if (a != 0 && d == a) begin
            add_event(0, -1, 1'b0);
            add_event(1, -1, 1'b0);
        end else begin
            add_event(0, 1, 1'b0);
        end
    endtask

    task automatic drain(input string name);
        int idle;
        int cyc;
        idle = 0;
        cyc  = 0;
        while (idle < 4 && cyc < 20) begin
            @(negedge clk);
            cyc++;
            if (master_out.valid) begin
                $display("%s: unexpected issue of %08h after the last expected event",
                         name, master_out.instr);
                failures++;
                idle = 0;
            end else begin
                idle++;
            end
        end
        if (idle < 4) begin
            $display("%s: the pipeline did not go idle", name);
            failures++;
        end
    endtask

    task automatic run_case(input int c);
        instr_t pushes [$];
        issue_t exp_m  [$];
        issue_t exp_s  [$];
        logic   exp_ds [$];
        instr_t lw_pre;
        instr_t sw_pre;
        int     got;
        int     cyc;
        // lw then a dependent sw stall the head so the case builds a backlog
        lw_pre = enc_i(OP_LW, 0, 28, 16'd0);
        sw_pre = enc_i(OP_SW, 28, 28, 16'd0);
        pushes = {lw_pre, sw_pre};
        exp_m  = {slot(1'b1, lw_pre), slot(1'b1, sw_pre)};
        exp_s  = {slot(1'b0, '0), slot(1'b0, '0)};
        exp_ds = {1'b0, 1'b0};
        for (int i = 0; i < case_len[c]; i++) begin
            pushes.push_back(case_instr[c][i]);
        end
        for (int e = 0; e < ev_cnt[c]; e++) begin
            exp_m.push_back(slot(1'b1, case_instr[c][ev_m[c][e]]));
            if (ev_s[c][e] < 0) begin
                exp_s.push_back(slot(1'b0, '0));
            end else begin
                exp_s.push_back(slot(1'b1, case_instr[c][ev_s[c][e]]));
            end
            exp_ds.push_back(ev_ds[c][e]);
        end
        got = 0;
        cyc = 0;
        while ((got < exp_m.size() || pushes.size() > 0) && cyc < CASE_TIMEOUT) begin
            @(negedge clk);
            cyc++;
            if (master_out.valid) begin
                if (got < exp_m.size()) begin
                    check_issue({case_name[c], " master"}, exp_m[got], master_out);
                    check_issue({case_name[c], " slave"}, exp_s[got], slave_out);
                    check_bit({case_name[c], " delay slot"}, exp_ds[got], slave_in_delayslot);
                end else begin
                    $display("%s: more issue events than expected", case_name[c]);
                    failures++;
                end
                got++;
            end
            if (pushes.size() > 0) begin
                push       = 1'b1;
                push_instr = pushes.pop_front();
            end else begin
                push       = 1'b0;
                push_instr = '0;
            end
        end
        push = 1'b0;
        if (got < exp_m.size()) begin
            $display("Case %s stalled: only %0d of %0d issue events seen in %0d cycles",
                     case_name[c], got, exp_m.size(), CASE_TIMEOUT);
            failures++;
        end
        drain(case_name[c]);
    endtask

    // chained loads stall the head every time, so the queue fills up
    task automatic run_fill();
        instr_t pushes [$];
        instr_t exp_q  [$];
        instr_t ld;
        int     got;
        int     cyc;
        logic   saw_full;
        for (int k = 0; k < FILL_COUNT; k++) begin
            ld = enc_i(OP_LW, 1, 1, 16'(k * 4));
            pushes.push_back(ld);
            exp_q.push_back(ld);
        end
        got      = 0;
        cyc      = 0;
        saw_full = 1'b0;
        while ((got < FILL_COUNT || pushes.size() > 0) && cyc < 200) begin
            @(negedge clk);
            cyc++;
            if (fifo_full) begin
                saw_full = 1'b1;
            end
            if (master_out.valid) begin
                if (exp_q.size() > 0) begin
                    check_issue("fifo_fill master", slot(1'b1, exp_q.pop_front()), master_out);
                    check_issue("fifo_fill slave", slot(1'b0, '0), slave_out);
                end else begin
                    $display("fifo_fill: more issue events than expected");
                    failures++;
                end
                got++;
            end
            push = (pushes.size() > 0) && !fifo_full;
            push_instr = push ? pushes.pop_front() : '0;
        end
        push = 1'b0;
        if (got < FILL_COUNT) begin
            $display("Case fifo_fill stalled: only %0d of %0d loads issued", got, FILL_COUNT);
            failures++;
        end
        if (!saw_full) begin
            $display("fifo_fill: fifo_full never went high");
            failures++;
        end
        drain("fifo_fill");
    endtask

    initial begin
        int cyc;
        push       = 1'b0;
        push_instr = '0;
        mismatches = 0;
        failures   = 0;
        n_cases    = 0;
        seed_val   = $urandom(SEED);
        build_table();
        cyc = 0;
        while (!arst_n && cyc < 100) begin
            @(negedge clk);
            cyc++;
        end
        if (!arst_n) begin
            $display("reset was never released");
            failures++;
        end else begin
            for (int c = 0; c < n_cases; c++) begin
                run_case(c);
            end
            run_fill();
        end
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- files.f
hw/issue_pkg.sv
hw/inst_fifo.sv
hw/inst_decode.sv
hw/issue_ctrl.sv
hw/pipe_tracker.sv
hw/issue_top.sv
bench/clk_gen.sv
bench/issue_tb.sv

//--- hw/inst_decode.sv
`timescale 1ns/1ps

module inst_decode (
    input  issue_pkg::instr_t instr,
    output issue_pkg::dec_t   dec
);
    import issue_pkg::*;

    funct_t    fn;
    reg_addr_t rd;

    assign fn = instr[5:0];
    assign rd = instr[15:11];

    always_comb begin
        dec       = '0;
        dec.op    = instr[31:26];
        dec.rs    = instr[25:21];
        dec.rt    = instr[20:16];

        case (dec.op)
            OP_R_TYPE: begin
                case (fn)
                    FN_JR: begin
                        dec.is_branch = 1'b1;
                    end
                    FN_SYSCALL, FN_BREAK: begin
                        dec.is_spec = 1'b1;  // traps
                    end
                    FN_MFHI, FN_MFLO: begin
                        dec.is_hilo = 1'b1;
                        dec.reg_wen = 1'b1;
                        dec.waddr   = rd;
                    end
                    FN_MTHI, FN_MTLO, FN_MULT, FN_DIV: begin
                        dec.is_hilo = 1'b1;  // writes hi/lo only
                    end
                    default: begin
                        dec.reg_wen = 1'b1;
                        dec.waddr   = rd;
                    end
                endcase
            end
            OP_LW: begin
                dec.mem_en   = 1'b1;
                dec.memtoreg = 1'b1;
                dec.reg_wen  = 1'b1;
                dec.waddr    = dec.rt;
            end
            OP_SW: begin
                dec.mem_en = 1'b1;
            end
            OP_BEQ, OP_BNE, OP_J: begin
                dec.is_branch = 1'b1;
            end
            OP_JAL: begin
                dec.is_branch = 1'b1;
                dec.reg_wen   = 1'b1;
                dec.waddr     = RA_REG;
            end
            OP_ADDI, OP_ORI: begin
                dec.reg_wen = 1'b1;
                dec.waddr   = dec.rt;
            end
            OP_COP0: begin
                dec.is_spec = 1'b1;
            end
            default: begin
                dec.reg_wen = 1'b0;  // unknown op, no side effects
            end
        endcase
    end

endmodule

//--- hw/inst_fifo.sv
`timescale 1ns/1ps

module inst_fifo (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 push,
    input  issue_pkg::instr_t    push_instr,
    input  logic                 pop_one,
    input  logic                 pop_two,
    output issue_pkg::instr_t    head0,
    output issue_pkg::instr_t    head1,
    output logic                 fifo_empty,
    output logic                 fifo_almost_empty,
    output logic                 fifo_full,
    output issue_pkg::fifo_cnt_t count
);
    import issue_pkg::*;

    typedef logic [FIFO_AW-1:0] ptr_t;

    instr_t    mem [FIFO_DEPTH];
    ptr_t      wr_ptr;
    ptr_t      rd_ptr;
    logic      push_ok;
    fifo_cnt_t pop_num;

    assign push_ok = push && !fifo_full;  // drop on full
    assign pop_num = fifo_cnt_t'(pop_one) + fifo_cnt_t'(pop_two);

    assign head0 = mem[rd_ptr];
    assign head1 = mem[rd_ptr + ptr_t'(1)];

    assign fifo_empty        = (count == '0);
    assign fifo_almost_empty = (count == fifo_cnt_t'(1));
    assign fifo_full         = (count == fifo_cnt_t'(FIFO_DEPTH));

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= push_instr;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + ptr_t'(1);  // wraps, depth is a power of two
            end
            rd_ptr <= rd_ptr + ptr_t'(pop_num);
            count  <= count + fifo_cnt_t'(push_ok) - pop_num;
        end
    end

    a_no_push_full: assert property (
        @(posedge clk) disable iff (!arst_n)
        push |-> !fifo_full
    ) else $error("inst_fifo: push while full, instruction dropped");

    a_pop_two_depth: assert property (
        @(posedge clk) disable iff (!arst_n)
        pop_two |-> (count >= fifo_cnt_t'(2))
    ) else $error("inst_fifo: double pop with fewer than two entries");

    a_pop_two_order: assert property (
        @(posedge clk) disable iff (!arst_n)
        pop_two |-> pop_one
    ) else $error("inst_fifo: pop_two without pop_one");

endmodule

//--- hw/issue_ctrl.sv
`timescale 1ns/1ps

module issue_ctrl (
    input  issue_pkg::dec_t   master_dec,
    input  issue_pkg::dec_t   slave_dec,
    input  issue_pkg::stage_t e_stage,
    input  issue_pkg::stage_t m_stage,
    input  logic              fifo_empty,
    input  logic              fifo_almost_empty,
    output logic              master_en,
    output logic              slave_en,
    output logic              slave_in_delayslot
);
    import issue_pkg::*;

    logic master_load_use;
    logic slave_dep;
    logic slave_blocked;
    logic slave_load_use;
    logic two_entries;

    // pending load result in a stage feeding this source register
    function automatic logic load_hit(input stage_t stg, input reg_addr_t src);
        return stg.valid && stg.memtoreg && (stg.waddr == src);
    endfunction

    assign two_entries = !(fifo_empty || fifo_almost_empty);

    assign master_load_use = load_hit(e_stage, master_dec.rs) ||
                             load_hit(e_stage, master_dec.rt) ||
                             load_hit(m_stage, master_dec.rs) ||
                             load_hit(m_stage, master_dec.rt);

    assign slave_load_use  = load_hit(e_stage, slave_dec.rs) ||
                             load_hit(e_stage, slave_dec.rt) ||
                             load_hit(m_stage, slave_dec.rs) ||
                             load_hit(m_stage, slave_dec.rt);

    assign master_en = !fifo_empty && !master_load_use;

    always_comb begin
        slave_dep = 1'b0;
        if (master_dec.reg_wen && (master_dec.waddr != '0)) begin
            if (slave_dec.op == OP_R_TYPE) begin
                slave_dep = (slave_dec.rs == master_dec.waddr) ||
                            (slave_dec.rt == master_dec.waddr);
            end else begin
                slave_dep = (slave_dec.rs == master_dec.waddr);  // rt is a dest here
            end
        end
    end

    assign slave_blocked = !master_en            ||
                           master_dec.mem_en     ||
                           slave_dec.is_branch   ||
                           slave_dec.mem_en      ||
                           slave_dec.is_hilo     ||
                           master_dec.is_spec    ||
                           slave_dec.is_spec;

    assign slave_en = two_entries && !slave_dep && !slave_blocked && !slave_load_use;

    assign slave_in_delayslot = master_dec.is_branch && slave_en;

endmodule

//--- hw/issue_pkg.sv
package issue_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    // primary opcodes
    localparam opcode_t OP_R_TYPE = 6'b000000;
    localparam opcode_t OP_J      = 6'b000010;
    localparam opcode_t OP_JAL    = 6'b000011;
    localparam opcode_t OP_BEQ    = 6'b000100;
    localparam opcode_t OP_BNE    = 6'b000101;
    localparam opcode_t OP_ADDI   = 6'b001000;
    localparam opcode_t OP_ORI    = 6'b001101;
    localparam opcode_t OP_COP0   = 6'b010000;
    localparam opcode_t OP_LW     = 6'b100011;
    localparam opcode_t OP_SW     = 6'b101011;

    // R-type function codes
    localparam funct_t FN_JR      = 6'b001000;
    localparam funct_t FN_SYSCALL = 6'b001100;
    localparam funct_t FN_BREAK   = 6'b001101;
    localparam funct_t FN_MFHI    = 6'b010000;
    localparam funct_t FN_MTHI    = 6'b010001;
    localparam funct_t FN_MFLO    = 6'b010010;
    localparam funct_t FN_MTLO    = 6'b010011;
    localparam funct_t FN_MULT    = 6'b011000;
    localparam funct_t FN_DIV     = 6'b011010;

    localparam reg_addr_t RA_REG = 5'd31;  // jal link register

    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

    typedef logic [3:0] fifo_cnt_t;  // holds 0..FIFO_DEPTH

    typedef struct packed {
        opcode_t   op;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t waddr;
        logic      reg_wen;
        logic      mem_en;
        logic      memtoreg;
        logic      is_branch;
        logic      is_hilo;
        logic      is_spec;    // privileged / trap
    } dec_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t waddr;
        logic      memtoreg;
    } stage_t;

    typedef struct packed {
        logic   valid;
        instr_t instr;
    } issue_t;

endpackage

//--- hw/issue_top.sv
`timescale 1ns/1ps

module issue_top (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              push,
    input  issue_pkg::instr_t push_instr,
    output logic              fifo_full,
    output issue_pkg::issue_t master_out,
    output issue_pkg::issue_t slave_out,
    output logic              slave_in_delayslot
);
    import issue_pkg::*;

    instr_t head0;
    instr_t head1;
    logic   fifo_empty;
    logic   fifo_almost_empty;
    dec_t   master_dec;
    dec_t   slave_dec;
    stage_t e_stage;
    stage_t m_stage;
    logic   master_en;
    logic   slave_en;
    logic   slave_ds;  // combinational delay-slot decision

    inst_fifo u_fifo (
        .clk               (clk),
        .arst_n            (arst_n),
        .push              (push),
        .push_instr        (push_instr),
        .pop_one           (master_en),
        .pop_two           (slave_en),
        .head0             (head0),
        .head1             (head1),
        .fifo_empty        (fifo_empty),
        .fifo_almost_empty (fifo_almost_empty),
        .fifo_full         (fifo_full),
        .count             ()
    );

    inst_decode u_dec_master (.instr(head0), .dec(master_dec));
    inst_decode u_dec_slave  (.instr(head1), .dec(slave_dec));

    issue_ctrl u_ctrl (
        .master_dec         (master_dec),
        .slave_dec          (slave_dec),
        .e_stage            (e_stage),
        .m_stage            (m_stage),
        .fifo_empty         (fifo_empty),
        .fifo_almost_empty  (fifo_almost_empty),
        .master_en          (master_en),
        .slave_en           (slave_en),
        .slave_in_delayslot (slave_ds)
    );

    pipe_tracker u_tracker (
        .clk                (clk),
        .arst_n             (arst_n),
        .master_en          (master_en),
        .slave_en           (slave_en),
        .slave_in_delayslot (slave_ds),
        .master_dec         (master_dec),
        .head0              (head0),
        .head1              (head1),
        .master_out         (master_out),
        .slave_out          (slave_out),
        .slave_delayslot_q  (slave_in_delayslot),
        .e_stage            (e_stage),
        .m_stage            (m_stage)
    );

endmodule

//--- hw/pipe_tracker.sv
`timescale 1ns/1ps

module pipe_tracker (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              master_en,
    input  logic              slave_en,
    input  logic              slave_in_delayslot,
    input  issue_pkg::dec_t   master_dec,
    input  issue_pkg::instr_t head0,
    input  issue_pkg::instr_t head1,
    output issue_pkg::issue_t master_out,
    output issue_pkg::issue_t slave_out,
    output logic              slave_delayslot_q,
    output issue_pkg::stage_t e_stage,
    output issue_pkg::stage_t m_stage
);
    import issue_pkg::*;

    logic   master_vld_q;
    logic   slave_vld_q;
    instr_t master_instr_q;
    instr_t slave_instr_q;
    stage_t e_next;

    always_comb begin
        e_next = '0;  // bubble when nothing issues
        if (master_en) begin
            e_next.valid    = 1'b1;
            e_next.waddr    = master_dec.waddr;
            e_next.memtoreg = master_dec.memtoreg;
        end
    end

    always_ff @(posedge clk) begin
        if (master_en) begin
            master_instr_q <= head0;
        end
        if (slave_en) begin
            slave_instr_q <= head1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            master_vld_q      <= 1'b0;
            slave_vld_q       <= 1'b0;
            slave_delayslot_q <= 1'b0;
            e_stage           <= '0;
            m_stage           <= '0;
        end else begin
            master_vld_q      <= master_en;
            slave_vld_q       <= slave_en;
            slave_delayslot_q <= slave_in_delayslot;
            e_stage           <= e_next;
            m_stage           <= e_stage;
        end
    end

    assign master_out = '{valid: master_vld_q, instr: master_instr_q};
    assign slave_out  = '{valid: slave_vld_q,  instr: slave_instr_q};

    a_delayslot_pair: assert property (
        @(posedge clk) disable iff (!arst_n)
        slave_delayslot_q |-> (slave_vld_q && master_vld_q)
    ) else $error("pipe_tracker: delay-slot flag without an issued pair");

endmodule
